// ==== uart_config.svh ====
// build-time constants for the uart subsystem
// UART_BIT_TIME must come out at 2 or more and UART_FIFO_DEPTH must be a power of two
// UART_RX_CREDITS must not exceed UART_FIFO_DEPTH
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// 25 MHz system clock, which is a 40 ns period
`define UART_CLK_HZ 25_000_000

// chosen so that one bit spans eight clocks
`define UART_BAUD 3_125_000

// clock cycles per serial bit, rounded down
`define UART_BIT_TIME (`UART_CLK_HZ / `UART_BAUD)

// receive FIFO entries and the credits each side holds after reset
`define UART_FIFO_DEPTH 4
`define UART_RX_CREDITS 2
`define UART_TX_CREDITS 1

`endif

// ==== uart_frame_pkg.sv ====
// types for the 8N1 serial frame and the receive FSM
// parity and other frame lengths are not supported
package uart_frame_pkg;

  // number of data bits in one frame, LSB goes first on the line
  localparam int unsigned UART_DATA_BITS = 8;

  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  // complete line word as the transmitter shifts it out
  // bit 0 is the start bit and bit 9 is the stop bit
  typedef logic [UART_DATA_BITS+1:0] uart_line_word_t;

  // received frame with its status flags
  // overrun marks the first frame stored after the FIFO had to drop one
  typedef struct packed {
    logic       overrun;
    logic       frame_err;
    uart_byte_t data;
  } uart_frame_t;

  // receive FSM states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

endpackage

// ==== uart_link_pkg.sv ====
// types for the credit links towards the consumer and the producer
// sized from UART_FIFO_DEPTH so a counter can hold the full depth
package uart_link_pkg;

`include "uart_config.svh"

  // credit and fill counters, 0 up to UART_FIFO_DEPTH inclusive
  typedef logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0] uart_credit_t;

  // FIFO read and write pointers
  // they wrap on their own because the depth is a power of two
  typedef logic [$clog2(`UART_FIFO_DEPTH)-1:0] uart_fifo_ptr_t;

endpackage

// ==== uart_bit_if.sv ====
// bit timing link between a serial user and its baud timer
// strobes are single-cycle and are only valid while busy is high
`timescale 1ns/1ps

interface uart_bit_if;

  // restart request from the user, reloads the timer count
  logic start;
  // strobe in the middle of each bit period
  logic half;
  // strobe at the end of each bit period
  logic tick;
  // set by start, cleared once the user drops run
  logic busy;

  modport user (
    output start,
    input  half,
    input  tick,
    input  busy
  );

  modport timer (
    input  start,
    output half,
    output tick,
    output busy
  );

endinterface

// ==== uart_baud_timer.sv ====
// bit timer shared by the receive and the transmit path
// half comes UART_BIT_TIME/2 cycles and tick UART_BIT_TIME cycles after start
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_baud_timer (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,
  uart_bit_if.timer bus
);

  localparam int unsigned BIT_TIME = `UART_BIT_TIME;
  localparam int unsigned CW = $clog2(BIT_TIME);

  // the count starts at RELOAD one cycle after start and reaches 0 on the tick
  localparam logic [CW-1:0] RELOAD = CW'(BIT_TIME - 1);
  // count value that lands exactly BIT_TIME/2 cycles after start
  localparam logic [CW-1:0] HALF_CNT = CW'(BIT_TIME - BIT_TIME / 2);

  logic [CW-1:0] cnt;
  logic          busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= '0;
      busy_q <= 1'b0;
    end else begin
      // a start always wins so the user can realign mid-frame
      if (bus.start) begin
        cnt <= RELOAD;
      end else if (busy_q) begin
        cnt <= (cnt == '0) ? RELOAD : cnt - 1'b1;
      end
      // busy holds for as long as the user keeps run high
      busy_q <= bus.start | (busy_q & run);
    end
  end

  // both strobes decode the same count, so they can never drift apart
  assign bus.half = busy_q && (cnt == HALF_CNT);
  assign bus.tick = busy_q && (cnt == '0);
  assign bus.busy = busy_q;

endmodule

// ==== uart_rx_fsm.sv ====
// 8N1 receive FSM, samples rx in the middle of each bit
// rx is asynchronous and goes through a two-flop synchronizer first
`timescale 1ns/1ps

module uart_rx_fsm import uart_frame_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  uart_bit_if.user    bit_tmr,
  output logic        run,
  output logic        frame_valid,
  output uart_frame_t frame
);

  uart_rx_state_e state_q;
  logic [2:0]     rx_sync;
  logic [2:0]     bit_cnt;
  uart_byte_t     shreg;
  logic           rx_s;
  logic           rx_fall;

  // rx_sync[1] is the first safe sample, rx_sync[2] is one clock older
  assign rx_s    = rx_sync[1];
  assign rx_fall = rx_sync[2] & ~rx_sync[1];

  // the timer runs for the whole frame and is released back in idle
  assign run = (state_q != RX_IDLE);

  // first start arms the timer on the falling edge of the start bit
  // the second one realigns it at mid-start so every later tick is a mid-bit
  assign bit_tmr.start =
    ((state_q == RX_IDLE) && rx_fall && !bit_tmr.busy) ||
    ((state_q == RX_START) && bit_tmr.half && !rx_s);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RX_IDLE;
      rx_sync     <= 3'b111;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      rx_sync     <= {rx_sync[1:0], rx};
      frame_valid <= 1'b0;
      unique case (state_q)
        RX_IDLE: begin
          // only a real high to low edge counts, so a low stop bit
          // cannot retrigger reception on its own
          if (bit_tmr.start) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (bit_tmr.half) begin
            // line back high at mid-start means it was a glitch
            if (rx_s) begin
              state_q <= RX_IDLE;
            end else begin
              bit_cnt <= '0;
              state_q <= RX_DATA;
            end
          end
        end
        RX_DATA: begin
          if (bit_tmr.tick) begin
            if (bit_cnt == 3'(UART_DATA_BITS - 1)) begin
              state_q <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        RX_STOP: begin
          // the frame is handed over one cycle after the stop sample
          if (bit_tmr.tick) begin
            frame_valid <= 1'b1;
            state_q     <= RX_IDLE;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // data path, shifting right so the first bit on the line ends up as the LSB
  always_ff @(posedge clk) begin
    if ((state_q == RX_DATA) && bit_tmr.tick) begin
      shreg <= {rx_s, shreg[UART_DATA_BITS-1:1]};
    end
    if ((state_q == RX_STOP) && bit_tmr.tick) begin
      frame.data      <= shreg;
      // a low stop bit is a framing error, the byte is kept as received
      frame.frame_err <= !rx_s;
      // overrun is decided further down, in the FIFO
      frame.overrun   <= 1'b0;
    end
  end

endmodule

// ==== uart_tx_serializer.sv ====
// 8N1 transmit shifter, one byte per credit
// the producer must not raise tx_valid while a byte is still on the line
`timescale 1ns/1ps

module uart_tx_serializer import uart_frame_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  uart_byte_t tx_data,
  uart_bit_if.user   bit_tmr,
  output logic       run,
  output logic       tx,
  output logic       tx_credit
);

  // start bit, eight data bits and the stop bit
  localparam int unsigned FRAME_BITS = UART_DATA_BITS + 2;

  uart_line_word_t shreg;
  logic            active_q;
  logic [3:0]      bit_cnt;

  // the timer restarts with the byte, so the first tick closes the start bit
  assign bit_tmr.start = !active_q && tx_valid;
  assign run           = active_q;

  // the line always shows bit 0 of the shift word
  // an idle word is all ones, which keeps the line high
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg     <= '1;
      active_q  <= 1'b0;
      bit_cnt   <= '0;
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= 1'b0;
      if (bit_tmr.start) begin
        // stop bit on top, start bit at the bottom
        shreg    <= {1'b1, tx_data, 1'b0};
        bit_cnt  <= '0;
        active_q <= 1'b1;
      end else if (active_q && bit_tmr.tick) begin
        // ones shift in from the top, so the line is high once all bits are out
        shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          // the stop bit has lasted its full time, hand the credit back
          active_q  <= 1'b0;
          tx_credit <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== uart_rx_credit_fifo.sv ====
// receive FIFO that releases one frame per consumer credit
// frames arriving while full are dropped, the next stored frame is flagged overrun
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx_credit_fifo import uart_frame_pkg::*, uart_link_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        frame_valid,
  input  uart_frame_t frame,
  input  logic        rx_credit,
  output logic        rx_valid,
  output uart_frame_t rx_frame
);

  localparam int unsigned DEPTH = `UART_FIFO_DEPTH;
  localparam uart_credit_t FULL_FILL = uart_credit_t'(DEPTH);
  localparam uart_credit_t INIT_CREDITS = uart_credit_t'(`UART_RX_CREDITS);

  uart_frame_t    mem [DEPTH];
  uart_frame_t    store;
  uart_fifo_ptr_t wr_ptr;
  uart_fifo_ptr_t rd_ptr;
  uart_credit_t   fill;
  uart_credit_t   credits;
  logic           ovr_pend;
  logic           full;
  logic           empty;
  logic           push;
  logic           pop;

  assign full  = (fill == FULL_FILL);
  assign empty = (fill == '0);
  assign push  = frame_valid && !full;
  // a frame leaves only while the consumer still holds a credit
  assign pop   = !empty && (credits != '0);

  // the pending overrun rides along with the next frame that fits
  always_comb begin
    store         = frame;
    store.overrun = frame.overrun | ovr_pend;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credits  <= INIT_CREDITS;
      ovr_pend <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill    <= fill + uart_credit_t'(push) - uart_credit_t'(pop);
      // a returned credit and a delivery in the same cycle cancel out
      credits <= credits + uart_credit_t'(rx_credit) - uart_credit_t'(pop);
      // a dropped frame sets the flag and a stored frame consumes it
      if (frame_valid) begin
        ovr_pend <= full;
      end
      rx_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= store;
    end
    if (pop) begin
      rx_frame <= mem[rd_ptr];
    end
  end

endmodule

// ==== uart_top.sv ====
// uart subsystem top, receive path into a credit FIFO plus a transmit shifter
// both links run on credits, no parity and no register interface
`timescale 1ns/1ps

module uart_top import uart_frame_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  input  logic        tx_valid,
  input  uart_byte_t  tx_data,
  input  logic        rx_credit,
  output logic        tx,
  output logic        tx_credit,
  output logic        rx_valid,
  output uart_frame_t rx_frame
);

  logic        rx_run;
  logic        tx_run;
  logic        frame_valid;
  uart_frame_t frame;

  // each direction keeps its own bit timing
  uart_bit_if rx_bit ();
  uart_bit_if tx_bit ();

  uart_baud_timer u_rx_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (rx_run),
    .bus   (rx_bit.timer)
  );

  uart_baud_timer u_tx_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (tx_run),
    .bus   (tx_bit.timer)
  );

  uart_rx_fsm u_rx_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx          (rx),
    .bit_tmr     (rx_bit.user),
    .run         (rx_run),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  uart_rx_credit_fifo u_rx_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .rx_credit   (rx_credit),
    .rx_valid    (rx_valid),
    .rx_frame    (rx_frame)
  );

  uart_tx_serializer u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .bit_tmr   (tx_bit.user),
    .run       (tx_run),
    .tx        (tx),
    .tx_credit (tx_credit)
  );

endmodule

// ==== tb_uart_top.sv ====
// self-checking testbench for uart_top, driven item by item from uart_testdata.txt
// assumes UART_BIT_TIME of at least 8 so that the glitch widths in the data stay below half a bit
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_top import uart_frame_pkg::*, uart_link_pkg::*;;

  localparam int BIT_TIME = `UART_BIT_TIME;
  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int MAX_ITEMS = 64;
  localparam int FIELDS = 5;
  // longest wait for expected frames once the line has gone quiet
  localparam int DRAIN_LIMIT = 12 * BIT_TIME * (DEPTH + 2);
  localparam logic [7:0] KIND_RX = 8'h00;
  localparam logic [7:0] KIND_TX = 8'h01;
  localparam logic [7:0] KIND_GLITCH = 8'h02;
  localparam logic [7:0] KIND_HOLD = 8'h03;

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        tx_valid;
  uart_byte_t  tx_data;
  logic        rx_credit;
  logic        tx;
  logic        tx_credit;
  logic        rx_valid;
  uart_frame_t rx_frame;

  // one hex word per field, five fields per test item
  logic [7:0]   tdata [MAX_ITEMS*FIELDS];
  int           item_count;
  logic         items_ready;
  uart_frame_t  expected [$];
  logic         hold_credits;
  int           owed_credits;
  int           tx_credits_held;
  uart_credit_t model_credits;
  uart_credit_t model_fill;
  int           frame_errors;
  int           byte_errors;
  int           level_errors;
  int           other_errors;

  uart_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .rx_credit (rx_credit),
    .tx        (tx),
    .tx_credit (tx_credit),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_frame(input uart_frame_t got, input uart_frame_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got data %h ferr %b ovr %b, expected data %h ferr %b ovr %b",
               $time, what, got.data, got.frame_err, got.overrun,
               exp.data, exp.frame_err, exp.overrun);
      frame_errors++;
    end
  endtask

  task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got %h, expected %h", $time, what, got, exp);
      byte_errors++;
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      level_errors++;
    end
  endtask

  // the consumer side, which checks every delivered frame and hands its credit back
  // while credits are held back it only remembers how many it owes
  always @(posedge clk) begin
    rx_credit <= 1'b0;
    if (rx_valid === 1'b1) begin
      if (expected.size() == 0) begin
        $display("unexpected frame on rx_valid at %0d ns, data %h", $time, rx_frame.data);
        other_errors++;
      end else begin
        check_frame(rx_frame, expected.pop_front(), "rx frame");
      end
      if (hold_credits) begin
        // every owed credit stands for a frame that used up one of the reset credits
        if (owed_credits >= `UART_RX_CREDITS) begin
          $display("frame delivered at %0d ns although the consumer held no credit", $time);
          other_errors++;
        end
        owed_credits++;
      end else begin
        rx_credit <= 1'b1;
      end
    end else if (!hold_credits && owed_credits > 0) begin
      owed_credits--;
      rx_credit <= 1'b1;
    end
  end

  // holds one level on rx for a full bit time
  task automatic drive_line_bit(input logic level);
    rx <= level;
    repeat (BIT_TIME) @(posedge clk);
  endtask

  // 8N1 frame with a chosen stop level, then two idle bits
  task automatic drive_rx_frame(input uart_byte_t data, input logic stop_bit);
    int i;
    drive_line_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_line_bit(data[i]);
    end
    drive_line_bit(stop_bit);
    drive_line_bit(1'b1);
    drive_line_bit(1'b1);
  endtask

  // short low pulse that the receiver has to reject at mid-start
  task automatic drive_glitch(input uart_byte_t width);
    rx <= 1'b0;
    repeat (width) @(posedge clk);
    rx <= 1'b1;
    repeat (2 * BIT_TIME) @(posedge clk);
  endtask

  task automatic wait_rx_drain();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("%0d expected frames never arrived on rx_valid", expected.size());
      other_errors++;
      expected.delete();
    end
  endtask

  // gives the consumer its credits back, after which the FIFO drains in order
  task automatic release_credits();
    hold_credits  <= 1'b0;
    model_fill    = '0;
    model_credits = uart_credit_t'(`UART_RX_CREDITS);
  endtask

  // sends one byte and samples the line in the middle of every bit
  // tx falls one cycle after tx_valid, so mid start is BIT_TIME/2 edges after that
  task automatic send_tx_byte(input uart_byte_t data);
    uart_byte_t got;
    int         i;
    int         waited;
    if (tx_credits_held == 0) begin
      $display("producer holds no tx credit for byte %h", data);
      other_errors++;
      return;
    end
    tx_credits_held--;
    tx_valid <= 1'b1;
    tx_data  <= data;
    @(posedge clk);
    tx_valid <= 1'b0;
    repeat (BIT_TIME / 2) @(posedge clk);
    check_level(tx, 1'b0, "tx start bit");
    for (i = 0; i < 8; i++) begin
      repeat (BIT_TIME) @(posedge clk);
      got[i] = tx;
    end
    check_byte(got, data, "tx data");
    repeat (BIT_TIME) @(posedge clk);
    check_level(tx, 1'b1, "tx stop bit");
    waited = 0;
    while (tx_credit !== 1'b1 && waited < 2 * BIT_TIME) begin
      @(posedge clk);
      waited++;
    end
    if (tx_credit === 1'b1) begin
      tx_credits_held++;
      @(posedge clk);
      check_level(tx_credit, 1'b0, "tx_credit after its pulse");
      check_level(tx, 1'b1, "tx after the frame");
    end else begin
      $display("no tx_credit pulse after byte %h", data);
      other_errors++;
    end
  endtask

  initial begin : main_flow
    int          idx;
    int          total;
    logic [7:0]  kind;
    uart_byte_t  data;
    logic        stop_bit;
    uart_frame_t exp;
    input_init: begin
      rst_n     = 1'b0;
      rx        = 1'b1;
      tx_valid  = 1'b0;
      tx_data   = '0;
      rx_credit = 1'b0;
    end
    hold_credits    = 1'b0;
    owed_credits    = 0;
    tx_credits_held = `UART_TX_CREDITS;
    frame_errors    = 0;
    byte_errors     = 0;
    level_errors    = 0;
    other_errors    = 0;
    items_ready     = 1'b0;
    model_fill      = '0;
    model_credits   = uart_credit_t'(`UART_RX_CREDITS);
    $readmemh("uart_testdata.txt", tdata);
    // the list ends at the first kind that is not a test item
    item_count = 0;
    while (item_count < MAX_ITEMS && tdata[FIELDS*item_count] < 8'h04) begin
      item_count++;
    end
    items_ready = 1'b1;
    if (item_count == 0) begin
      $display("no test items could be read from uart_testdata.txt");
      other_errors++;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_level(tx, 1'b1, "tx after reset");
    check_level(rx_valid, 1'b0, "rx_valid after reset");
    check_level(tx_credit, 1'b0, "tx_credit after reset");
    for (idx = 0; idx < item_count; idx++) begin
      kind          = tdata[FIELDS*idx];
      data          = tdata[FIELDS*idx+1];
      stop_bit      = tdata[FIELDS*idx+2][0];
      exp.data      = data;
      exp.frame_err = tdata[FIELDS*idx+3][0];
      exp.overrun   = tdata[FIELDS*idx+4][0];
      if (kind != KIND_HOLD && hold_credits) begin
        release_credits();
      end
      case (kind)
        KIND_RX: begin
          expected.push_back(exp);
          drive_rx_frame(data, stop_bit);
          wait_rx_drain();
        end
        KIND_TX: begin
          send_tx_byte(data);
        end
        KIND_GLITCH: begin
          drive_glitch(data);
        end
        default: begin
          // held frames pass while credits last, then fill the FIFO, then get dropped
          hold_credits <= 1'b1;
          if (model_fill != uart_credit_t'(DEPTH)) begin
            expected.push_back(exp);
            if (model_credits != '0) begin
              model_credits--;
            end else begin
              model_fill++;
            end
          end
          drive_rx_frame(data, stop_bit);
        end
      endcase
    end
    if (hold_credits) begin
      release_credits();
    end
    wait_rx_drain();
    // a few quiet bit times so a stray frame would still show up
    repeat (4 * BIT_TIME) @(posedge clk);
    total = frame_errors + byte_errors + level_errors + other_errors;
    $display("errors: frame %0d, byte %0d, line level %0d, other %0d, total %0d",
             frame_errors, byte_errors, level_errors, other_errors, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // each item gets twelve bit times, four times over, and one spare item covers reset
  initial begin : watchdog
    longint unsigned limit_ns;
    wait (items_ready === 1'b1);
    limit_ns = longint'(item_count + 1) * 12 * BIT_TIME * 40 * 4;
    #(limit_ns);
    $display("watchdog timeout, the run did not finish within %0d ns", limit_ns);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== uart_testdata.txt ====
// columns in hex: kind byte stop_bit frame_err overrun
// kind 0 rx frame, 1 tx byte, 2 glitch (byte is its low width in clocks), 3 rx frame with credits held
0 a5 1 0 0
0 3c 1 0 0
0 00 1 0 0
0 ff 1 0 0
0 5a 0 1 0
2 02 1 0 0
2 03 1 0 0
0 81 1 0 0
1 a5 1 0 0
1 0f 1 0 0
1 c3 1 0 0
0 7e 0 1 0
3 11 1 0 0
3 22 1 0 0
3 33 1 0 0
3 44 1 0 0
3 55 0 1 0
3 66 1 0 0
3 77 1 0 0
0 88 1 0 1
0 99 1 0 0
1 e7 1 0 0
f 00 0 0 0

// ==== list.f ====
+incdir+.
uart_frame_pkg.sv
uart_link_pkg.sv
uart_bit_if.sv
uart_baud_timer.sv
uart_rx_fsm.sv
uart_tx_serializer.sv
uart_rx_credit_fifo.sv
uart_top.sv
tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: uart_subsystem

sources:
  - include_dirs:
      - .
    files:
      - uart_frame_pkg.sv
      - uart_link_pkg.sv
      - uart_bit_if.sv
      - uart_baud_timer.sv
      - uart_rx_fsm.sv
      - uart_tx_serializer.sv
      - uart_rx_credit_fifo.sv
      - uart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_top.sv
